// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_clock_mgmt
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+rtl
rtl/clock_mgmt_pkg.sv
rtl/reg_clock_mgmt.sv
rtl/mmcm_drp_master.sv
rtl/clkgen_model.sv
rtl/phase_shift_ctrl.sv
rtl/adc_clock_model.sv
rtl/clock_mgmt_top.sv
tb/tb_clock_mgmt.sv

// ==== rtl/adc_clock_model.sv ====
`timescale 1ns/1ps
`include "clock_mgmt_defines.svh"

module adc_clock_model (
    input  logic clk_usb,
    input  logic rst_n,
    input  logic clkgen,
    input  logic adc_div4_sel,
    input  logic gen_locked,
    input  logic psen,
    input  logic psincdec,
    output logic psdone,
    output logic adc_locked,
    output logic adc_clk_out
);

    logic                     clkgen_d; // previous clkgen sample
    logic                     adc_clk_q; // ADC clock before phase taps
    logic                     skip_q; // div4 toggles on every second rise
    logic [`PSDONE_DELAY-1:0] ps_pipe; // psen travelling toward psdone
    logic                     dir_q;
    logic [1:0]               tap; // coarse phase position
    logic [3:0]               dly; // phase delay line

    wire clk_rise = clkgen && !clkgen_d;
    wire clk_edge = clkgen ^ clkgen_d;

    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            clkgen_d   <= 1'b0;
            adc_clk_q  <= 1'b0;
            skip_q     <= 1'b0;
            ps_pipe    <= '0;
            dir_q      <= 1'b0;
            tap        <= '0;
            dly        <= '0;
            adc_locked <= 1'b0;
        end else begin
            clkgen_d <= clkgen;
            if (!adc_div4_sel) begin
                if (clk_edge)
                    adc_clk_q <= ~adc_clk_q; // x1 tracks clkgen one cycle late
            end else if (clk_rise) begin
                skip_q <= ~skip_q;
                if (skip_q)
                    adc_clk_q <= ~adc_clk_q; // period is four clkgen periods
            end
            ps_pipe <= {ps_pipe[`PSDONE_DELAY-2:0], psen};
            if (psen)
                dir_q <= psincdec;
            if (psdone)
                tap <= dir_q ? tap + 2'd1 : tap - 2'd1;
            dly        <= {dly[2:0], adc_clk_q};
            adc_locked <= gen_locked; // one cycle behind the generator
        end
    end

    assign psdone      = ps_pipe[`PSDONE_DELAY-1];
    assign adc_clk_out = dly[tap];

endmodule

// ==== rtl/clkgen_model.sv ====
`timescale 1ns/1ps
`include "clock_mgmt_defines.svh"

module clkgen_model (
    input  logic                      clk_usb,
    input  logic                      rst_n,
    input  clock_mgmt_pkg::drp_addr_t drp_addr,
    input  clock_mgmt_pkg::drp_data_t drp_din,
    input  logic                      drp_dwe,
    input  logic                      drp_den,
    output clock_mgmt_pkg::drp_data_t drp_dout,
    output logic                      drp_drdy,
    output logic                      clkgen,
    output logic                      gen_locked
);

    clock_mgmt_pkg::drp_data_t regs [16]; // addresses alias modulo 16
    clock_mgmt_pkg::drp_data_t div_reg; // divide entry, starts at the default divide
    logic [`DRP_RDY_DELAY-1:0] rdy_pipe; // den travelling toward drdy
    logic [7:0]                half; // effective half period
    logic [7:0]                hcnt;
    logic [$clog2(`LOCK_CYCLES+1)-1:0] lock_cnt;

    wire drp_wr  = drp_den && drp_dwe;
    wire div_sel = (drp_addr[3:0] == 4'(`DRP_DIV_ADDR));

    always_ff @(posedge clk_usb) begin
        if (drp_wr)
            regs[drp_addr[3:0]] <= drp_din;
        if (drp_den)
            drp_dout <= div_sel ? div_reg : regs[drp_addr[3:0]]; // held until drdy
    end

    assign half = (div_reg[7:0] == 8'd0) ? 8'd1 : div_reg[7:0]; // 0 behaves as 1

    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            div_reg  <= `DRP_DIV_RESET;
            rdy_pipe <= '0;
            hcnt     <= '0;
            clkgen   <= 1'b0;
            lock_cnt <= '0;
        end else begin
            rdy_pipe <= {rdy_pipe[`DRP_RDY_DELAY-2:0], drp_den};
            if (drp_wr && div_sel) begin
                div_reg <= drp_din;
                hcnt    <= '0; // restart the divider on the new value
                clkgen  <= 1'b0;
            end else if (hcnt == half - 8'd1) begin
                hcnt   <= '0;
                clkgen <= ~clkgen;
            end else begin
                hcnt <= hcnt + 8'd1;
            end
            if (drp_wr)
                lock_cnt <= '0; // any reconfig drops lock
            else if (!gen_locked)
                lock_cnt <= lock_cnt + 1'b1;
        end
    end

    assign drp_drdy   = rdy_pipe[`DRP_RDY_DELAY-1];
    assign gen_locked = (lock_cnt == `LOCK_CYCLES);

    // one transaction in flight at a time
    a_den_single: assert property (@(posedge clk_usb) disable iff (!rst_n)
        drp_den |-> rdy_pipe == '0);

endmodule

// ==== rtl/clock_mgmt_defines.svh ====
`ifndef CLOCK_MGMT_DEFINES_SVH
`define CLOCK_MGMT_DEFINES_SVH

// register interface
`define BYTECNT_W 7

// register map
`define ADDR_CLKSETTINGS 8'h26 // byte0 bit0 adc div4 select, byte1 status (read only)
`define ADDR_PHASE 8'h19 // 9-bit phase, writing byte1 loads the request
`define ADDR_DRP 8'h3A // staged DRP access, writing byte3 starts it

// status bits in ADDR_CLKSETTINGS byte 1
`define STAT_ADC_LOCKED 0
`define STAT_GEN_LOCKED 1
`define STAT_PHASE_DONE 2

// clock generator model
`define DRP_DIV_ADDR 7'h08 // low byte sets clkgen half period in clk_usb cycles
`define DRP_DIV_RESET 16'h0004 // divide value after reset
`define DRP_RDY_DELAY 2 // den to drdy latency
`define LOCK_CYCLES 64 // cycles from reconfig to lock

// phase shift handshake
`define PSDONE_DELAY 3 // psen to psdone latency

`endif

// ==== rtl/clock_mgmt_pkg.sv ====
package clock_mgmt_pkg;

    typedef logic [7:0] reg_addr_t; // register address
    typedef logic [7:0] reg_byte_t; // register data byte
    typedef logic [6:0] drp_addr_t; // DRP address
    typedef logic [15:0] drp_data_t; // DRP data word

    // two's complement, -256 .. 255
    typedef logic signed [8:0] phase_t;

    // DRP master FSM
    typedef enum logic [1:0] {
        DRP_IDLE, // waiting for a request, issues den when one is latched
        DRP_WAIT_RDY, // den sent, waiting on drdy
        DRP_DONE // data captured, back to idle
    } drp_state_e;

    // phase shift FSM
    typedef enum logic [1:0] {
        PS_IDLE, // compare actual against target
        PS_STEP, // psen pulse
        PS_WAIT_DONE // waiting for psdone
    } ps_state_e;

endpackage

// ==== rtl/clock_mgmt_top.sv ====
`timescale 1ns/1ps
`include "clock_mgmt_defines.svh"

module clock_mgmt_top (
    input  logic                      clk_usb,
    input  logic                      rst_n,
    input  clock_mgmt_pkg::reg_addr_t reg_address,
    input  logic [`BYTECNT_W-1:0]     reg_bytecnt,
    input  clock_mgmt_pkg::reg_byte_t reg_datai,
    output clock_mgmt_pkg::reg_byte_t reg_datao,
    input  logic                      reg_read,
    input  logic                      reg_write,
    output logic                      clkgen,
    output logic                      adc_clk_out,
    output logic                      gen_locked,
    output logic                      adc_locked
);

    logic                      adc_div4_sel;
    clock_mgmt_pkg::phase_t    phase_requested;
    clock_mgmt_pkg::phase_t    phase_actual;
    logic                      phase_load;
    logic                      phase_done;
    logic                      drp_req;
    logic                      drp_req_we;
    clock_mgmt_pkg::drp_addr_t drp_req_addr;
    clock_mgmt_pkg::drp_data_t drp_req_data;
    clock_mgmt_pkg::drp_data_t drp_rdata;
    logic                      drp_busy;
    clock_mgmt_pkg::drp_addr_t drp_addr; // DRP bus to the generator
    clock_mgmt_pkg::drp_data_t drp_din;
    clock_mgmt_pkg::drp_data_t drp_dout;
    logic                      drp_dwe;
    logic                      drp_den;
    logic                      drp_drdy;
    logic                      psen; // phase step handshake
    logic                      psincdec;
    logic                      psdone;

    reg_clock_mgmt u_reg_clock_mgmt (
        .clk_usb, .rst_n, .reg_address, .reg_bytecnt, .reg_datai, .reg_datao,
        .reg_read, .reg_write, .adc_div4_sel, .phase_requested, .phase_load,
        .phase_actual, .phase_done, .drp_req, .drp_req_we, .drp_req_addr,
        .drp_req_data, .drp_rdata, .drp_busy, .gen_locked, .adc_locked
    );

    mmcm_drp_master u_mmcm_drp_master (
        .clk_usb, .rst_n, .drp_req, .drp_req_we, .drp_req_addr, .drp_req_data,
        .drp_busy, .drp_rdata, .drp_addr, .drp_din, .drp_dwe, .drp_den,
        .drp_dout, .drp_drdy
    );

    clkgen_model u_clkgen_model (
        .clk_usb, .rst_n, .drp_addr, .drp_din, .drp_dwe, .drp_den, .drp_dout,
        .drp_drdy, .clkgen, .gen_locked
    );

    phase_shift_ctrl u_phase_shift_ctrl (
        .clk_usb, .rst_n, .phase_requested, .phase_load, .phase_actual,
        .phase_done, .psen, .psincdec, .psdone
    );

    adc_clock_model u_adc_clock_model (
        .clk_usb, .rst_n, .clkgen, .adc_div4_sel, .gen_locked, .psen,
        .psincdec, .psdone, .adc_locked, .adc_clk_out
    );

endmodule

// ==== rtl/mmcm_drp_master.sv ====
`timescale 1ns/1ps
`include "clock_mgmt_defines.svh"

module mmcm_drp_master (
    input  logic                      clk_usb,
    input  logic                      rst_n,
    input  logic                      drp_req,
    input  logic                      drp_req_we,
    input  clock_mgmt_pkg::drp_addr_t drp_req_addr,
    input  clock_mgmt_pkg::drp_data_t drp_req_data,
    output logic                      drp_busy,
    output clock_mgmt_pkg::drp_data_t drp_rdata,
    output clock_mgmt_pkg::drp_addr_t drp_addr,
    output clock_mgmt_pkg::drp_data_t drp_din,
    output logic                      drp_dwe,
    output logic                      drp_den,
    input  clock_mgmt_pkg::drp_data_t drp_dout,
    input  logic                      drp_drdy
);

    clock_mgmt_pkg::drp_state_e state;
    logic                       we_q; // latched direction

    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            state     <= clock_mgmt_pkg::DRP_IDLE;
            drp_busy  <= 1'b0;
            we_q      <= 1'b0;
            drp_addr  <= '0;
            drp_din   <= '0;
            drp_rdata <= '0;
        end else begin
            if (drp_req && !drp_busy) begin // requests while busy are lost
                drp_busy <= 1'b1;
                we_q     <= drp_req_we;
                drp_addr <= drp_req_addr;
                drp_din  <= drp_req_data;
            end
            case (state)
                clock_mgmt_pkg::DRP_IDLE: begin
                    if (drp_busy)
                        state <= clock_mgmt_pkg::DRP_WAIT_RDY; // den goes out this cycle
                end
                clock_mgmt_pkg::DRP_WAIT_RDY: begin
                    if (drp_drdy) begin
                        if (!we_q)
                            drp_rdata <= drp_dout; // keep old data on writes
                        drp_busy <= 1'b0;
                        state    <= clock_mgmt_pkg::DRP_DONE;
                    end
                end
                default: state <= clock_mgmt_pkg::DRP_IDLE;
            endcase
        end
    end

    assign drp_den = (state == clock_mgmt_pkg::DRP_IDLE) && drp_busy; // one cycle after req
    assign drp_dwe = drp_den && we_q;

    // drdy comes back a fixed latency after den
    a_drdy_latency: assert property (@(posedge clk_usb) disable iff (!rst_n)
        drp_drdy |-> $past(drp_den, `DRP_RDY_DELAY));

    // the generator must not answer without an outstanding den
    a_no_stray_drdy: assert property (@(posedge clk_usb) disable iff (!rst_n)
        drp_drdy |-> state != clock_mgmt_pkg::DRP_IDLE);

endmodule

// ==== rtl/phase_shift_ctrl.sv ====
`timescale 1ns/1ps
`include "clock_mgmt_defines.svh"

module phase_shift_ctrl (
    input  logic                   clk_usb,
    input  logic                   rst_n,
    input  clock_mgmt_pkg::phase_t phase_requested,
    input  logic                   phase_load,
    output clock_mgmt_pkg::phase_t phase_actual,
    output logic                   phase_done,
    output logic                   psen,
    output logic                   psincdec,
    input  logic                   psdone
);

    clock_mgmt_pkg::ps_state_e state;
    clock_mgmt_pkg::phase_t    target; // latched request
    logic                      dir_q; // direction of the step in flight

    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            state        <= clock_mgmt_pkg::PS_IDLE;
            target       <= '0;
            phase_actual <= '0;
            dir_q        <= 1'b0;
        end else begin
            if (phase_load)
                target <= phase_requested; // retargets even mid-step
            case (state)
                clock_mgmt_pkg::PS_IDLE: begin
                    if (phase_actual != target)
                        state <= clock_mgmt_pkg::PS_STEP;
                end
                clock_mgmt_pkg::PS_STEP: begin
                    dir_q <= psincdec;
                    state <= clock_mgmt_pkg::PS_WAIT_DONE;
                end
                default: begin
                    if (psdone) begin
                        phase_actual <= dir_q ? phase_actual + 9'sd1 : phase_actual - 9'sd1;
                        state        <= clock_mgmt_pkg::PS_IDLE;
                    end
                end
            endcase
        end
    end

    assign psen       = (state == clock_mgmt_pkg::PS_STEP);
    assign psincdec   = (target > phase_actual); // signed compare
    assign phase_done = (phase_actual == target);

    // a step is only answered while one is outstanding
    a_psdone_waiting: assert property (@(posedge clk_usb) disable iff (!rst_n)
        psdone |-> state == clock_mgmt_pkg::PS_WAIT_DONE);

    // clock model answers each psen after a fixed delay
    a_psdone_latency: assert property (@(posedge clk_usb) disable iff (!rst_n)
        psdone |-> $past(psen, `PSDONE_DELAY));

endmodule

// ==== rtl/reg_clock_mgmt.sv ====
`timescale 1ns/1ps
`include "clock_mgmt_defines.svh"

module reg_clock_mgmt (
    input  logic                      clk_usb,
    input  logic                      rst_n,
    input  clock_mgmt_pkg::reg_addr_t reg_address,
    input  logic [`BYTECNT_W-1:0]     reg_bytecnt,
    input  clock_mgmt_pkg::reg_byte_t reg_datai,
    output clock_mgmt_pkg::reg_byte_t reg_datao,
    input  logic                      reg_read,
    input  logic                      reg_write,
    output logic                      adc_div4_sel,
    output clock_mgmt_pkg::phase_t    phase_requested,
    output logic                      phase_load,
    input  clock_mgmt_pkg::phase_t    phase_actual,
    input  logic                      phase_done,
    output logic                      drp_req,
    output logic                      drp_req_we,
    output clock_mgmt_pkg::drp_addr_t drp_req_addr,
    output clock_mgmt_pkg::drp_data_t drp_req_data,
    input  clock_mgmt_pkg::drp_data_t drp_rdata,
    input  logic                      drp_busy,
    input  logic                      gen_locked,
    input  logic                      adc_locked
);

    clock_mgmt_pkg::reg_byte_t phase_lo; // low phase byte, held until byte 1 arrives

    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            adc_div4_sel    <= 1'b0; // x1 clock after reset
            phase_lo        <= '0;
            phase_requested <= '0;
            phase_load      <= 1'b0;
            drp_req         <= 1'b0;
            drp_req_we      <= 1'b0;
            drp_req_addr    <= '0;
            drp_req_data    <= '0;
        end else begin
            phase_load <= 1'b0; // strobes last one cycle
            drp_req    <= 1'b0;
            if (reg_write) begin
                case (reg_address)
                    `ADDR_CLKSETTINGS: begin
                        if (reg_bytecnt == 'd0)
                            adc_div4_sel <= reg_datai[0]; // byte 1 is status, writes dropped
                    end
                    `ADDR_PHASE: begin
                        if (reg_bytecnt == 'd0) begin
                            phase_lo <= reg_datai;
                        end else if (reg_bytecnt == 'd1) begin
                            phase_requested <= {reg_datai[0], phase_lo}; // sign bit in byte 1
                            phase_load      <= 1'b1;
                        end
                    end
                    `ADDR_DRP: begin
                        case (reg_bytecnt)
                            'd0: drp_req_addr       <= reg_datai[6:0];
                            'd1: drp_req_data[7:0]  <= reg_datai;
                            'd2: drp_req_data[15:8] <= reg_datai;
                            'd3: begin
                                drp_req_we <= reg_datai[0];
                                drp_req    <= 1'b1; // master drops it when busy
                            end
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // same-cycle readback
    always_comb begin
        reg_datao = '0; // unmapped and idle read 0
        if (reg_read) begin
            case (reg_address)
                `ADDR_CLKSETTINGS: begin
                    if (reg_bytecnt == 'd0) begin
                        reg_datao = {7'd0, adc_div4_sel};
                    end else if (reg_bytecnt == 'd1) begin
                        reg_datao[`STAT_ADC_LOCKED] = adc_locked;
                        reg_datao[`STAT_GEN_LOCKED] = gen_locked;
                        reg_datao[`STAT_PHASE_DONE] = phase_done;
                    end
                end
                `ADDR_PHASE: begin
                    if (reg_bytecnt == 'd0)
                        reg_datao = phase_actual[7:0];
                    else if (reg_bytecnt == 'd1)
                        reg_datao = {7'd0, phase_actual[8]};
                end
                `ADDR_DRP: begin
                    if (reg_bytecnt == 'd0)
                        reg_datao = drp_rdata[7:0]; // last read word
                    else if (reg_bytecnt == 'd1)
                        reg_datao = drp_rdata[15:8];
                    else if (reg_bytecnt == 'd2)
                        reg_datao = {7'd0, drp_busy};
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== tb/tb_clock_mgmt.sv ====
`timescale 1ns/1ps
`include "clock_mgmt_defines.svh"

module tb_clock_mgmt;

    localparam int N_TESTS   = 24;
    localparam int K_DRP_WR  = 0; // kinds of table entries
    localparam int K_DRP_RD  = 1;
    localparam int K_DIVIDE  = 2;
    localparam int K_LOCK    = 3;
    localparam int K_PHASE   = 4;
    localparam int K_ADC_SEL = 5;
    localparam int K_REG_WR  = 6;
    localparam int K_REG_RD  = 7;

    logic                      clk_usb = 1'b0;
    logic                      rst_n;
    clock_mgmt_pkg::reg_addr_t reg_address;
    logic [`BYTECNT_W-1:0]     reg_bytecnt;
    clock_mgmt_pkg::reg_byte_t reg_datai;
    clock_mgmt_pkg::reg_byte_t reg_datao;
    logic                      reg_read;
    logic                      reg_write;
    logic                      clkgen;
    logic                      adc_clk_out;
    logic                      gen_locked;
    logic                      adc_locked;

    string                     test_name [N_TESTS];
    int                        test_kind [N_TESTS];
    clock_mgmt_pkg::reg_addr_t test_addr [N_TESTS]; // register or DRP address
    clock_mgmt_pkg::drp_data_t test_value [N_TESTS];
    clock_mgmt_pkg::drp_data_t test_expected [N_TESTS];
    int                        n_added = 0;
    logic [15:0]               lfsr_state = 16'd63089;

    clock_mgmt_top u_clock_mgmt_top (
        .clk_usb, .rst_n, .reg_address, .reg_bytecnt, .reg_datai, .reg_datao,
        .reg_read, .reg_write, .clkgen, .adc_clk_out, .gen_locked, .adc_locked
    );

    always #10 clk_usb = ~clk_usb; // 50 MHz

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_byte(input string name, input clock_mgmt_pkg::reg_byte_t exp,
                              input clock_mgmt_pkg::reg_byte_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %02h actual %02h", name, exp, act));
    endtask

    task automatic check_phase(input string name, input clock_mgmt_pkg::phase_t exp,
                               input clock_mgmt_pkg::phase_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_drp(input string name, input clock_mgmt_pkg::drp_data_t exp,
                             input clock_mgmt_pkg::drp_data_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %04h actual %04h", name, exp, act));
    endtask

    task automatic check_period(input string name, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic reg_write_byte(input clock_mgmt_pkg::reg_addr_t addr, input int cnt,
                                  input clock_mgmt_pkg::reg_byte_t data);
        @(posedge clk_usb);
        reg_write   <= 1'b1; // one-cycle strobe
        reg_address <= addr;
        reg_bytecnt <= `BYTECNT_W'(cnt);
        reg_datai   <= data;
        @(posedge clk_usb);
        reg_write   <= 1'b0;
    endtask

    task automatic reg_read_byte(input clock_mgmt_pkg::reg_addr_t addr, input int cnt,
                                 output clock_mgmt_pkg::reg_byte_t data);
        @(posedge clk_usb);
        reg_read    <= 1'b1;
        reg_address <= addr;
        reg_bytecnt <= `BYTECNT_W'(cnt);
        @(negedge clk_usb);
        data = reg_datao; // readback is combinational, stable mid-cycle
        @(posedge clk_usb);
        reg_read    <= 1'b0;
    endtask

    task automatic wait_drp_idle();
        clock_mgmt_pkg::reg_byte_t st;
        st = 8'h01;
        while (st[0])
            reg_read_byte(`ADDR_DRP, 2, st); // byte 2 bit 0 is busy
    endtask

    task automatic drp_write(input clock_mgmt_pkg::drp_addr_t a,
                             input clock_mgmt_pkg::drp_data_t d);
        reg_write_byte(`ADDR_DRP, 0, {1'b0, a});
        reg_write_byte(`ADDR_DRP, 1, d[7:0]);
        reg_write_byte(`ADDR_DRP, 2, d[15:8]);
        reg_write_byte(`ADDR_DRP, 3, 8'h01); // write, starts the transaction
        wait_drp_idle();
    endtask

    task automatic drp_read(input clock_mgmt_pkg::drp_addr_t a,
                            output clock_mgmt_pkg::drp_data_t d);
        clock_mgmt_pkg::reg_byte_t lo;
        clock_mgmt_pkg::reg_byte_t hi;
        reg_write_byte(`ADDR_DRP, 0, {1'b0, a});
        reg_write_byte(`ADDR_DRP, 3, 8'h00); // read
        wait_drp_idle();
        reg_read_byte(`ADDR_DRP, 0, lo);
        reg_read_byte(`ADDR_DRP, 1, hi);
        d = {hi, lo};
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic next_phase(output clock_mgmt_pkg::phase_t p);
        p = '0;
        for (int b = 0; b < 9; b++) begin
            p          = {p[7:0], lfsr_state[15]}; // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic pick_clock(input logic use_adc);
        return use_adc ? adc_clk_out : clkgen;
    endfunction

    // clk_usb cycles between two rising edges, sampled on falling edges
    task automatic measure_period(input logic use_adc, output int cycles);
        logic prev;
        logic cur;
        int   n;
        bit   seen;
        seen   = 1'b0;
        n      = 0;
        cycles = 0;
        @(negedge clk_usb);
        prev = pick_clock(use_adc);
        while (cycles == 0) begin
            @(negedge clk_usb);
            cur = pick_clock(use_adc);
            n   = n + 1;
            if (cur && !prev) begin
                if (seen)
                    cycles = n;
                seen = 1'b1;
                n    = 0;
            end
            prev = cur;
        end
    endtask

    task automatic measure_settled(input logic use_adc, output int cycles);
        measure_period(use_adc, cycles); // first period may straddle a mode change
        measure_period(use_adc, cycles);
    endtask

    task automatic add_test(input string name, input int kind,
                            input clock_mgmt_pkg::reg_addr_t addr,
                            input clock_mgmt_pkg::drp_data_t value,
                            input clock_mgmt_pkg::drp_data_t expected);
        if (n_added < N_TESTS) begin
            test_name[n_added]     = name;
            test_kind[n_added]     = kind;
            test_addr[n_added]     = addr;
            test_value[n_added]    = value;
            test_expected[n_added] = expected;
        end
        n_added = n_added + 1;
    endtask

    task automatic fill_table();
        add_test("drp_wr_a", K_DRP_WR, 8'h03, 16'h1234, 16'h0000);
        add_test("drp_wr_b", K_DRP_WR, 8'h05, 16'hBEEF, 16'h0000);
        add_test("drp_rd_a", K_DRP_RD, 8'h03, 16'h0000, 16'h1234);
        add_test("drp_rd_b", K_DRP_RD, 8'h05, 16'h0000, 16'hBEEF);
        add_test("drp_wr_alias", K_DRP_WR, 8'h15, 16'h5A5A, 16'h0000); // lands on entry 5
        add_test("drp_rd_alias", K_DRP_RD, 8'h05, 16'h0000, 16'h5A5A);
        add_test("drp_rd_alias_hi", K_DRP_RD, 8'h13, 16'h0000, 16'h1234);
        add_test("div_3", K_DIVIDE, 8'h00, 16'h0003, 16'd6); // period is 2 x divide
        add_test("drp_rd_div", K_DRP_RD, 8'h08, 16'h0000, 16'h0003);
        add_test("div_0", K_DIVIDE, 8'h00, 16'h0000, 16'd2); // 0 acts as 1
        add_test("div_5", K_DIVIDE, 8'h00, 16'h0005, 16'd10);
        add_test("lock_after_wr", K_LOCK, 8'h03, 16'h1234, 16'h0003);
        add_test("phase_rand_0", K_PHASE, 8'h00, 16'h0000, 16'h0000);
        add_test("phase_rand_1", K_PHASE, 8'h00, 16'h0000, 16'h0000);
        add_test("phase_rand_2", K_PHASE, 8'h00, 16'h0000, 16'h0000);
        add_test("phase_rand_3", K_PHASE, 8'h00, 16'h0000, 16'h0000);
        add_test("adc_x1", K_ADC_SEL, 8'h00, 16'h0000, 16'd10); // clkgen still at divide 5
        add_test("adc_div4", K_ADC_SEL, 8'h00, 16'h0001, 16'd40); // four clkgen periods
        add_test("settings_wr_1", K_REG_WR, `ADDR_CLKSETTINGS, 16'h0001, 16'h0000);
        add_test("settings_rd_1", K_REG_RD, `ADDR_CLKSETTINGS, 16'h0000, 16'h0001);
        add_test("settings_wr_0", K_REG_WR, `ADDR_CLKSETTINGS, 16'h00FE, 16'h0000);
        add_test("settings_rd_0", K_REG_RD, `ADDR_CLKSETTINGS, 16'h0000, 16'h0000);
        add_test("unmapped_55", K_REG_RD, 8'h55, 16'h0000, 16'h0000);
        add_test("unmapped_00", K_REG_RD, 8'h00, 16'h0000, 16'h0000);
    endtask

    task automatic run_test(input int i);
        clock_mgmt_pkg::drp_data_t rd;
        clock_mgmt_pkg::reg_byte_t b0;
        clock_mgmt_pkg::reg_byte_t b1;
        clock_mgmt_pkg::phase_t    p;
        clock_mgmt_pkg::phase_t    pa;
        int                        per_clk;
        int                        per_adc;
        case (test_kind[i])
            K_DRP_WR: drp_write(test_addr[i][6:0], test_value[i]);
            K_DRP_RD: begin
                drp_read(test_addr[i][6:0], rd);
                check_drp(test_name[i], test_expected[i], rd);
            end
            K_DIVIDE: begin
                drp_write(`DRP_DIV_ADDR, test_value[i]);
                measure_settled(1'b0, per_clk);
                check_period(test_name[i], int'(test_expected[i]), per_clk);
            end
            K_LOCK: begin
                repeat (`LOCK_CYCLES + 8) @(posedge clk_usb); // start from a locked generator
                reg_read_byte(`ADDR_CLKSETTINGS, 1, b1);
                check_byte(test_name[i], test_expected[i][7:0], b1 & 8'h03);
                drp_write(test_addr[i][6:0], test_value[i]);
                reg_read_byte(`ADDR_CLKSETTINGS, 1, b1);
                check_byte(test_name[i], 8'h00, b1 & 8'h02); // gen lock dropped
                @(negedge clk_usb);
                check_byte(test_name[i], 8'h00, {6'd0, gen_locked, adc_locked}); // lock pins
                repeat (`LOCK_CYCLES + 8) @(posedge clk_usb);
                reg_read_byte(`ADDR_CLKSETTINGS, 1, b1);
                check_byte(test_name[i], test_expected[i][7:0], b1 & 8'h03); // gen and adc
                @(negedge clk_usb);
                check_byte(test_name[i], test_expected[i][7:0],
                           {6'd0, gen_locked, adc_locked});
            end
            K_PHASE: begin
                next_phase(p);
                reg_write_byte(`ADDR_PHASE, 0, p[7:0]);
                reg_write_byte(`ADDR_PHASE, 1, {7'd0, p[8]}); // loads the request
                repeat (2) @(posedge clk_usb);
                b1 = 8'h00;
                while (!b1[`STAT_PHASE_DONE])
                    reg_read_byte(`ADDR_CLKSETTINGS, 1, b1);
                reg_read_byte(`ADDR_PHASE, 0, b0);
                reg_read_byte(`ADDR_PHASE, 1, b1);
                pa = {b1[0], b0};
                check_phase(test_name[i], p, pa);
            end
            K_ADC_SEL: begin
                reg_write_byte(`ADDR_CLKSETTINGS, 0, test_value[i][7:0]);
                measure_settled(1'b1, per_adc);
                check_period(test_name[i], int'(test_expected[i]), per_adc);
            end
            K_REG_WR: reg_write_byte(test_addr[i], 0, test_value[i][7:0]);
            K_REG_RD: begin
                reg_read_byte(test_addr[i], 0, b0);
                check_byte(test_name[i], test_expected[i][7:0], b0);
            end
            default: abort_run($sformatf("unknown test kind in table entry %0d", i));
        endcase
    endtask

    initial begin
        rst_n       = 1'b0;
        reg_address = '0;
        reg_bytecnt = '0;
        reg_datai   = '0;
        reg_read    = 1'b0;
        reg_write   = 1'b0;
        fill_table();
        if (n_added != N_TESTS)
            abort_run("test table size does not match the number of entries declared");
        repeat (16) @(posedge clk_usb);
        rst_n <= 1'b1;
        for (int i = 0; i < N_TESTS; i++)
            run_test(i);
        $display("Simulation finished: PASS");
        $finish;
    end

    // budget of 2000 cycles per table entry
    initial begin
        repeat (N_TESTS * 2000) @(posedge clk_usb);
        abort_run("timeout: the test table did not complete within the cycle budget");
    end

endmodule
